/* src/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

    //////////////////////////////
    // datapath widths
    //////////////////////////////

    // register word width
    localparam int DATA_W = 32;

    // immediate field carried by every instruction
    localparam int IMM_W = 16;

    // shift amount comes from the low immediate bits
    localparam int SHAMT_W = $clog2(DATA_W);

    //////////////////////////////
    // lane opcodes
    //////////////////////////////

    typedef enum logic [2:0] {
        // rs + sign-extended imm
        ALU_ADD = 3'd0,
        // rs - sign-extended imm
        ALU_SUB = 3'd1,
        // logic ops take the zero-extended imm
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        // shifts by imm[SHAMT_W-1:0]
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        // imm into the upper half with rs ignored
        ALU_LUI = 3'd7
    } alu_op_e;

    // logic ops and shifts see a zero-extended immediate
    function automatic logic imm_is_signed(input alu_op_e op);
        return (op == ALU_ADD) || (op == ALU_SUB);
    endfunction

endpackage

`default_nettype wire

/* src/alu_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_lane (
    input  wire  pipe_pkg::alu_op_e      op,
    input  wire  [pipe_pkg::DATA_W-1:0]  operand,
    input  wire  [pipe_pkg::IMM_W-1:0]   imm,
    output logic [pipe_pkg::DATA_W-1:0]  result
);

    import pipe_pkg::*;

    // extended immediate for this opcode
    logic [DATA_W-1:0]  imm_ext;
    // shift distance
    logic [SHAMT_W-1:0] shamt;
    // immediate placed in the upper half for lui
    logic [DATA_W-1:0]  imm_upper;

    //////////////////////////////
    // operand preparation
    //////////////////////////////

    always_comb begin
        if (imm_is_signed(op)) begin
            imm_ext = {{(DATA_W - IMM_W){imm[IMM_W-1]}}, imm};
        end else begin
            imm_ext = {{(DATA_W - IMM_W){1'b0}}, imm};
        end
    end

    assign shamt     = imm[SHAMT_W-1:0];
    assign imm_upper = {imm, {(DATA_W - IMM_W){1'b0}}};

    //////////////////////////////
    // operation
    //////////////////////////////

    always_comb begin
        case (op)
            ALU_ADD: begin
                result = operand + imm_ext;
            end
            ALU_SUB: begin
                result = operand - imm_ext;
            end
            ALU_AND: begin
                result = operand & imm_ext;
            end
            ALU_OR: begin
                result = operand | imm_ext;
            end
            ALU_XOR: begin
                result = operand ^ imm_ext;
            end
            ALU_SLL: begin
                result = operand << shamt;
            end
            ALU_SRL: begin
                result = operand >> shamt;
            end
            ALU_LUI: begin
                result = imm_upper;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile #(
    parameter int REG_COUNT = 32,
    localparam int ADDR_W = $clog2(REG_COUNT)
) (
    input  wire                          clk,
    input  wire                          w_ena,

    input  wire  [ADDR_W-1:0]            r_addr_1,
    output logic [pipe_pkg::DATA_W-1:0]  r_data_1,

    input  wire  [ADDR_W-1:0]            r_addr_2,
    output logic [pipe_pkg::DATA_W-1:0]  r_data_2,

    input  wire  [ADDR_W-1:0]            w_addr_1,
    input  wire  [pipe_pkg::DATA_W-1:0]  w_data_1,

    input  wire  [ADDR_W-1:0]            w_addr_2,
    input  wire  [pipe_pkg::DATA_W-1:0]  w_data_2
);

    import pipe_pkg::*;

    // entry 0 of the storage is never written
    logic [DATA_W-1:0] mem [REG_COUNT];

    // per-port write qualifiers
    logic wr_1;
    logic wr_2;

    assign wr_1 = w_ena && (w_addr_1 != '0);
    assign wr_2 = w_ena && (w_addr_2 != '0);

    //////////////////////////////
    // write side
    //////////////////////////////

    // port 2 carries the younger lane and wins on a collision
    always_ff @(posedge clk) begin
        if (wr_1 && (w_addr_1 != w_addr_2)) begin
            mem[w_addr_1] <= w_data_1;
        end
        if (wr_2) begin
            mem[w_addr_2] <= w_data_2;
        end
    end

    //////////////////////////////
    // read side
    //////////////////////////////

    // zero register, then bypass from the writes of this cycle, then storage
    function automatic logic [DATA_W-1:0] read_word(input logic [ADDR_W-1:0] addr);
        logic [DATA_W-1:0] word;
        if (addr == '0) begin
            word = '0;
        end else if (wr_2 && (addr == w_addr_2)) begin
            word = w_data_2;
        end else if (wr_1 && (addr == w_addr_1)) begin
            word = w_data_1;
        end else begin
            word = mem[addr];
        end
        return word;
    endfunction

    // each port compares only its own address
    always_comb begin
        r_data_1 = read_word(r_addr_1);
    end

    always_comb begin
        r_data_2 = read_word(r_addr_2);
    end

endmodule

`default_nettype wire

/* src/writeback_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module writeback_stage #(
    parameter int REG_COUNT = 32,
    localparam int ADDR_W = $clog2(REG_COUNT)
) (
    input  wire                          clk,
    input  wire                          arst_n,

    // lane results from execute
    input  wire                          valid_0,
    input  wire                          valid_1,
    input  wire  [ADDR_W-1:0]            rd_0,
    input  wire  [ADDR_W-1:0]            rd_1,
    input  wire  [pipe_pkg::DATA_W-1:0]  result_0,
    input  wire  [pipe_pkg::DATA_W-1:0]  result_1,

    // register file write ports
    output logic                         w_ena,
    output logic [ADDR_W-1:0]            w_addr_1,
    output logic [ADDR_W-1:0]            w_addr_2,
    output logic [pipe_pkg::DATA_W-1:0]  w_data_1,
    output logic [pipe_pkg::DATA_W-1:0]  w_data_2,

    // retired results
    output logic                         wb_valid_0,
    output logic                         wb_valid_1,
    output logic [ADDR_W-1:0]            wb_rd_0,
    output logic [ADDR_W-1:0]            wb_rd_1,
    output logic [pipe_pkg::DATA_W-1:0]  wb_data_0,
    output logic [pipe_pkg::DATA_W-1:0]  wb_data_1
);

    import pipe_pkg::*;

    logic              valid_q_0;
    logic              valid_q_1;
    logic [ADDR_W-1:0] rd_q_0;
    logic [ADDR_W-1:0] rd_q_1;
    logic [DATA_W-1:0] data_q_0;
    logic [DATA_W-1:0] data_q_1;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q_0 <= 1'b0;
            valid_q_1 <= 1'b0;
        end else begin
            valid_q_0 <= valid_0;
            valid_q_1 <= valid_1;
        end
    end

    // payload only moves with a valid instruction
    always_ff @(posedge clk) begin
        if (valid_0) begin
            rd_q_0   <= rd_0;
            data_q_0 <= result_0;
        end
        if (valid_1) begin
            rd_q_1   <= rd_1;
            data_q_1 <= result_1;
        end
    end

    // an idle lane targets register 0 so the register file drops it
    assign w_ena    = valid_q_0 | valid_q_1;
    assign w_addr_1 = valid_q_0 ? rd_q_0 : '0;
    assign w_addr_2 = valid_q_1 ? rd_q_1 : '0;
    assign w_data_1 = data_q_0;
    assign w_data_2 = data_q_1;

    assign wb_valid_0 = valid_q_0;
    assign wb_valid_1 = valid_q_1;
    assign wb_rd_0    = rd_q_0;
    assign wb_rd_1    = rd_q_1;
    assign wb_data_0  = data_q_0;
    assign wb_data_1  = data_q_1;

endmodule

`default_nettype wire

/* src/dual_alu_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module dual_alu_pipe #(
    parameter int REG_COUNT = 32,
    localparam int ADDR_W = $clog2(REG_COUNT)
) (
    input  wire                          clk,
    input  wire                          arst_n,

    // lane 0 issue
    input  wire                          issue_valid_0,
    input  wire  pipe_pkg::alu_op_e      issue_op_0,
    input  wire  [ADDR_W-1:0]            issue_rd_0,
    input  wire  [ADDR_W-1:0]            issue_rs_0,
    input  wire  [pipe_pkg::IMM_W-1:0]   issue_imm_0,

    // lane 1 carries the younger instruction of the pair
    input  wire                          issue_valid_1,
    input  wire  pipe_pkg::alu_op_e      issue_op_1,
    input  wire  [ADDR_W-1:0]            issue_rd_1,
    input  wire  [ADDR_W-1:0]            issue_rs_1,
    input  wire  [pipe_pkg::IMM_W-1:0]   issue_imm_1,

    // results appear one cycle after issue
    output logic                         wb_valid_0,
    output logic [ADDR_W-1:0]            wb_rd_0,
    output logic [pipe_pkg::DATA_W-1:0]  wb_data_0,
    output logic                         wb_valid_1,
    output logic [ADDR_W-1:0]            wb_rd_1,
    output logic [pipe_pkg::DATA_W-1:0]  wb_data_1
);

    import pipe_pkg::*;

    //////////////////////////////
    // internal nets
    //////////////////////////////

    logic [DATA_W-1:0] operand_0;
    logic [DATA_W-1:0] operand_1;
    logic [DATA_W-1:0] result_0;
    logic [DATA_W-1:0] result_1;

    logic              w_ena;
    logic [ADDR_W-1:0] w_addr_1;
    logic [ADDR_W-1:0] w_addr_2;
    logic [DATA_W-1:0] w_data_1;
    logic [DATA_W-1:0] w_data_2;

    // execute
    alu_lane lane_0 (
        .op      (issue_op_0),
        .operand (operand_0),
        .imm     (issue_imm_0),
        .result  (result_0)
    );

    alu_lane lane_1 (
        .op      (issue_op_1),
        .operand (operand_1),
        .imm     (issue_imm_1),
        .result  (result_1)
    );

    // writeback register stage
    writeback_stage #(
        .REG_COUNT (REG_COUNT)
    ) u_writeback (
        .clk        (clk),
        .arst_n     (arst_n),
        .valid_0    (issue_valid_0),
        .valid_1    (issue_valid_1),
        .rd_0       (issue_rd_0),
        .rd_1       (issue_rd_1),
        .result_0   (result_0),
        .result_1   (result_1),
        .w_ena      (w_ena),
        .w_addr_1   (w_addr_1),
        .w_addr_2   (w_addr_2),
        .w_data_1   (w_data_1),
        .w_data_2   (w_data_2),
        .wb_valid_0 (wb_valid_0),
        .wb_valid_1 (wb_valid_1),
        .wb_rd_0    (wb_rd_0),
        .wb_rd_1    (wb_rd_1),
        .wb_data_0  (wb_data_0),
        .wb_data_1  (wb_data_1)
    );

    // lane 0 on ports 1, lane 1 on ports 2
    regfile #(
        .REG_COUNT (REG_COUNT)
    ) u_regfile (
        .clk      (clk),
        .w_ena    (w_ena),
        .r_addr_1 (issue_rs_0),
        .r_data_1 (operand_0),
        .r_addr_2 (issue_rs_1),
        .r_data_2 (operand_1),
        .w_addr_1 (w_addr_1),
        .w_data_1 (w_data_1),
        .w_addr_2 (w_addr_2),
        .w_data_2 (w_data_2)
    );

endmodule

`default_nettype wire

/* sim/dual_alu_pipe_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module dual_alu_pipe_sva #(
    parameter int REG_COUNT = 32,
    localparam int ADDR_W = $clog2(REG_COUNT)
) (
    input wire                          clk,
    input wire                          arst_n,
    input wire                          issue_valid_0,
    input wire                          issue_valid_1,
    input wire [ADDR_W-1:0]             issue_rs_0,
    input wire [ADDR_W-1:0]             issue_rs_1,
    input wire [pipe_pkg::DATA_W-1:0]   operand_0,
    input wire [pipe_pkg::DATA_W-1:0]   operand_1,
    input wire                          w_ena,
    input wire                          wb_valid_0,
    input wire                          wb_valid_1
);

    int fail_count = 0;

    // nothing retires or writes while reset is held
    reset_quiet: assert property (@(posedge clk)
        !arst_n |-> !wb_valid_0 && !wb_valid_1 && !w_ena)
    else begin
        fail_count++;
        $error("result strobe or register write enable high during reset");
    end

    latency_0: assert property (@(posedge clk) disable iff (!arst_n)
        wb_valid_0 == $past(issue_valid_0))
    else begin
        fail_count++;
        $error("lane 0 result strobe not exactly one cycle after issue");
    end

    latency_1: assert property (@(posedge clk) disable iff (!arst_n)
        wb_valid_1 == $past(issue_valid_1))
    else begin
        fail_count++;
        $error("lane 1 result strobe not exactly one cycle after issue");
    end

    // a read of register 0 is zero even while something targets it
    zero_read: assert property (@(posedge clk) disable iff (!arst_n)
        ((issue_rs_0 != '0) || (operand_0 == '0)) && ((issue_rs_1 != '0) || (operand_1 == '0)))
    else begin
        fail_count++;
        $error("register 0 read returned nonzero data");
    end

endmodule

bind dual_alu_pipe dual_alu_pipe_sva #(.REG_COUNT(REG_COUNT)) sva (
    .clk           (clk),
    .arst_n        (arst_n),
    .issue_valid_0 (issue_valid_0),
    .issue_valid_1 (issue_valid_1),
    .issue_rs_0    (issue_rs_0),
    .issue_rs_1    (issue_rs_1),
    .operand_0     (operand_0),
    .operand_1     (operand_1),
    .w_ena         (w_ena),
    .wb_valid_0    (wb_valid_0),
    .wb_valid_1    (wb_valid_1)
);

`default_nettype wire

/* sim/tb_dual_alu_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dual_alu_pipe;

    import pipe_pkg::*;

    localparam int REG_COUNT = 32;
    localparam int ADDR_W = $clog2(REG_COUNT);
    localparam int OP_REPS = 4;
    localparam int RAND_CYCLES = 300;
    // init, opcodes, reg 0, forwarding, same destination, in-pair read, random
    localparam int ISSUE_CYCLES = REG_COUNT + 8 * OP_REPS + 4 + 8 + 12 + 6 + RAND_CYCLES;
    localparam int CYCLE_LIMIT = ISSUE_CYCLES + 50;

    logic              clk;
    logic              arst_n;
    logic              issue_valid_0;
    logic              issue_valid_1;
    alu_op_e           issue_op_0;
    alu_op_e           issue_op_1;
    logic [ADDR_W-1:0] issue_rd_0;
    logic [ADDR_W-1:0] issue_rd_1;
    logic [ADDR_W-1:0] issue_rs_0;
    logic [ADDR_W-1:0] issue_rs_1;
    logic [IMM_W-1:0]  issue_imm_0;
    logic [IMM_W-1:0]  issue_imm_1;
    logic              wb_valid_0;
    logic              wb_valid_1;
    logic [ADDR_W-1:0] wb_rd_0;
    logic [ADDR_W-1:0] wb_rd_1;
    logic [DATA_W-1:0] wb_data_0;
    logic [DATA_W-1:0] wb_data_1;

    // expected results wait one cycle until the writeback stage shows them
    logic [DATA_W-1:0] expect_data_0;
    logic [DATA_W-1:0] expect_data_1;
    logic              expect_valid_q_0;
    logic              expect_valid_q_1;
    logic [ADDR_W-1:0] expect_rd_q_0;
    logic [ADDR_W-1:0] expect_rd_q_1;
    logic [DATA_W-1:0] expect_data_q_0;
    logic [DATA_W-1:0] expect_data_q_1;

    logic [DATA_W-1:0] model [REG_COUNT];
    int check_errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int errors_at_start = 0;
    int cycle_count = 0;

    dual_alu_pipe #(.REG_COUNT(REG_COUNT)) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Checks failed");
            $finish;
        end
    end

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            expect_valid_q_0 <= 1'b0;
            expect_valid_q_1 <= 1'b0;
        end else begin
            expect_valid_q_0 <= issue_valid_0;
            expect_valid_q_1 <= issue_valid_1;
            expect_rd_q_0    <= issue_rd_0;
            expect_rd_q_1    <= issue_rd_1;
            expect_data_q_0  <= expect_data_0;
            expect_data_q_1  <= expect_data_1;
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    strobe_0: assert property (@(posedge clk) disable iff (!arst_n)
        wb_valid_0 == expect_valid_q_0)
    else begin
        check_errors++;
        $display("error %0t: lane 0 result strobe does not follow its issue strobe", $time);
    end

    strobe_1: assert property (@(posedge clk) disable iff (!arst_n)
        wb_valid_1 == expect_valid_q_1)
    else begin
        check_errors++;
        $display("error %0t: lane 1 result strobe does not follow its issue strobe", $time);
    end

    result_0: assert property (@(posedge clk) disable iff (!arst_n)
        expect_valid_q_0 |-> (wb_rd_0 == expect_rd_q_0) && (wb_data_0 == expect_data_q_0))
    else begin
        check_errors++;
        $display("error %0t: lane 0 destination or data differs from the model", $time);
    end

    result_1: assert property (@(posedge clk) disable iff (!arst_n)
        expect_valid_q_1 |-> (wb_rd_1 == expect_rd_q_1) && (wb_data_1 == expect_data_q_1))
    else begin
        check_errors++;
        $display("error %0t: lane 1 destination or data differs from the model", $time);
    end

    //////////////////////////////
    // model and stimulus
    //////////////////////////////

    function automatic logic [DATA_W-1:0] model_read(input logic [ADDR_W-1:0] addr);
        return (addr == '0) ? '0 : model[addr];
    endfunction

    function automatic logic [DATA_W-1:0] expected_result(input alu_op_e op,
            input logic [DATA_W-1:0] src, input logic [IMM_W-1:0] imm);
        logic [DATA_W-1:0] sext;
        logic [DATA_W-1:0] zext;
        sext = {{16{imm[15]}}, imm};
        zext = {16'h0000, imm};
        case (op)
            ALU_ADD: return src + sext;
            ALU_SUB: return src - sext;
            ALU_AND: return src & zext;
            ALU_OR:  return src | zext;
            ALU_XOR: return src ^ zext;
            ALU_SLL: return src << imm[4:0];
            ALU_SRL: return src >> imm[4:0];
            default: return {imm, 16'h0000};
        endcase
    endfunction

    function automatic int total_errors();
        return check_errors + DUT.sva.fail_count;
    endfunction

    function automatic logic [ADDR_W-1:0] pick_reg(input int lo);
        return ADDR_W'($urandom_range(REG_COUNT - 1, lo));
    endfunction

    function automatic alu_op_e pick_op();
        return alu_op_e'(3'($urandom_range(7, 0)));
    endfunction

    task automatic issue_pair(
        input logic v0, input alu_op_e op0, input logic [ADDR_W-1:0] rd0,
        input logic [ADDR_W-1:0] rs0, input logic [IMM_W-1:0] imm0,
        input logic v1, input alu_op_e op1, input logic [ADDR_W-1:0] rd1,
        input logic [ADDR_W-1:0] rs1, input logic [IMM_W-1:0] imm1
    );
        logic [DATA_W-1:0] res_0;
        logic [DATA_W-1:0] res_1;
        @(negedge clk);
        // both lanes see the state from before the pair
        res_0 = expected_result(op0, model_read(rs0), imm0);
        res_1 = expected_result(op1, model_read(rs1), imm1);
        issue_valid_0 = v0;
        issue_op_0    = op0;
        issue_rd_0    = rd0;
        issue_rs_0    = rs0;
        issue_imm_0   = imm0;
        expect_data_0 = res_0;
        issue_valid_1 = v1;
        issue_op_1    = op1;
        issue_rd_1    = rd1;
        issue_rs_1    = rs1;
        issue_imm_1   = imm1;
        expect_data_1 = res_1;
        // lane 1 is younger, so its write lands last
        if (v0 && (rd0 != '0)) begin
            model[rd0] = res_0;
        end
        if (v1 && (rd1 != '0)) begin
            model[rd1] = res_1;
        end
    endtask

    task automatic end_test(input string name);
        issue_pair(1'b0, ALU_ADD, '0, '0, '0, 1'b0, ALU_ADD, '0, '0, '0);
        @(posedge clk);
        @(negedge clk);
        if (total_errors() == errors_at_start) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d failed checks", name, total_errors() - errors_at_start);
        end
        errors_at_start = total_errors();
    endtask

    initial begin
        int unsigned seed_ret;
        logic [ADDR_W-1:0] a;
        logic [ADDR_W-1:0] b;
        arst_n = 1'b0;
        {issue_valid_0, issue_valid_1} = '0;
        issue_op_0 = ALU_ADD;
        issue_op_1 = ALU_ADD;
        {issue_rd_0, issue_rs_0, issue_rd_1, issue_rs_1} = '0;
        {issue_imm_0, issue_imm_1, expect_data_0, expect_data_1} = '0;
        seed_ret = $urandom(32'h8c3d_ae99);
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // lane 0 loads each register with lui and lane 1 ors it one cycle later through forwarding
        for (int k = 1; k <= REG_COUNT; k++) begin
            a = ADDR_W'(k);
            b = ADDR_W'(k - 1);
            issue_pair(k < REG_COUNT, ALU_LUI, a, '0, IMM_W'($urandom),
                       k > 1, ALU_OR, b, b, IMM_W'($urandom));
        end
        for (int n = 0; n < 8 * OP_REPS; n++) begin
            issue_pair(1'b1, alu_op_e'(3'(n)), pick_reg(1), pick_reg(1), IMM_W'($urandom),
                       1'b1, alu_op_e'(3'(n)), pick_reg(1), pick_reg(1), IMM_W'($urandom));
        end
        end_test("init and opcodes");

        for (int n = 0; n < 2; n++) begin
            issue_pair(1'b1, ALU_ADD, '0, pick_reg(1), IMM_W'($urandom),
                       1'b1, ALU_LUI, '0, '0, 16'h8001);
            issue_pair(1'b1, ALU_ADD, pick_reg(1), '0, IMM_W'($urandom),
                       1'b1, ALU_OR, pick_reg(1), '0, IMM_W'($urandom));
        end
        end_test("register 0");

        for (int n = 0; n < 4; n++) begin
            a = pick_reg(1);
            b = ADDR_W'((a % (REG_COUNT - 1)) + 1);
            issue_pair(1'b1, ALU_ADD, a, pick_reg(1), IMM_W'($urandom),
                       1'b1, ALU_XOR, b, pick_reg(1), IMM_W'($urandom));
            // even rounds read the own lane's result and odd rounds the other lane's
            issue_pair(1'b1, ALU_SUB, pick_reg(1), (n % 2 == 0) ? a : b, IMM_W'($urandom),
                       1'b1, ALU_SLL, pick_reg(1), (n % 2 == 0) ? b : a, IMM_W'($urandom));
        end
        end_test("back-to-back forwarding");

        for (int n = 0; n < 4; n++) begin
            a = pick_reg(1);
            b = ADDR_W'((a % (REG_COUNT - 1)) + 1);
            issue_pair(1'b1, ALU_ADD, a, pick_reg(1), IMM_W'($urandom),
                       1'b1, ALU_XOR, a, pick_reg(1), IMM_W'($urandom));
            issue_pair(1'b1, ALU_OR, b, a, 16'h0000, 1'b0, ALU_ADD, '0, '0, '0);
            issue_pair(1'b0, ALU_ADD, '0, '0, '0, 1'b1, ALU_ADD, b, a, 16'h0000);
        end
        end_test("same destination");

        for (int n = 0; n < 6; n++) begin
            a = pick_reg(1);
            issue_pair(1'b1, pick_op(), a, pick_reg(1), IMM_W'($urandom),
                       1'b1, ALU_ADD, pick_reg(1), a, IMM_W'($urandom));
        end
        end_test("read inside a pair");

        for (int n = 0; n < RAND_CYCLES; n++) begin
            issue_pair($urandom_range(3, 0) != 0, pick_op(), pick_reg(0), pick_reg(0),
                       IMM_W'($urandom), $urandom_range(3, 0) != 0, pick_op(), pick_reg(0),
                       pick_reg(0), IMM_W'($urandom));
        end
        end_test("random traffic");

        $display("summary: %0d tests passed, %0d tests failed, %0d failed checks",
                 tests_passed, tests_failed, total_errors());
        if ((tests_failed == 0) && (total_errors() == 0)) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
src/pipe_pkg.sv
src/alu_lane.sv
src/regfile.sv
src/writeback_stage.sv
src/dual_alu_pipe.sv
sim/dual_alu_pipe_sva.sv
sim/tb_dual_alu_pipe.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the dual ALU pipeline testbench with Verilator
set -euo pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
    --top-module tb_dual_alu_pipe \
    --Mdir "$BUILD_DIR" \
    -f tb.f

# let the run continue past assertion errors so the summary is printed
"./$BUILD_DIR/Vtb_dual_alu_pipe" +verilator+error+limit+1000 2>&1 | tee "$LOG"

if grep -q "Checks failed" "$LOG"; then
    echo "simulation FAILED, see $LOG"
    exit 1
fi

if ! grep -q "All checks passed" "$LOG"; then
    echo "simulation ended without a result, see $LOG"
    exit 1
fi

echo "simulation passed"
